// File: hdl/stream_pkg.sv
/* shared widths and memory depth for the load streamer:
   data word, byte strobe, byte offset, word/byte address and transfer length */

package stream_pkg;

  // data word and its byte lanes
  localparam int DATA_W = 32;
  localparam int STRB_W = 4;

  // byte offset inside a word, log2 of STRB_W
  localparam int OFS_W = 2;

  // shared word memory
  localparam int MEM_WORDS = 256;
  localparam int WADDR_W   = 8;

  // byte address covers the whole memory
  localparam int BADDR_W = WADDR_W + OFS_W;

  // transfer length in bytes, zero is not a legal length
  localparam int LEN_W = 10;

endpackage

// File: hdl/shared_mem.sv
/* word memory with a host write port, a stream read port
   and a fixed-priority arbiter that puts the host write first */

`timescale 1ns/1ps

module shared_mem
  import stream_pkg::*;
(
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               host_we_i,
  input  logic [WADDR_W-1:0] host_addr_i,
  input  logic [DATA_W-1:0]  host_wdata_i,
  input  logic               rd_req_i,
  input  logic [WADDR_W-1:0] rd_addr_i,
  output logic               rd_gnt_o,
  output logic [DATA_W-1:0]  rd_data_o
);

  logic [DATA_W-1:0] mem_q [MEM_WORDS];

  // the host write always wins the single port
  assign rd_gnt_o = rd_req_i & ~host_we_i;

  // zero-latency read
  assign rd_data_o = mem_q[rd_addr_i];

  always_ff @(posedge clk_i) begin
    if (host_we_i) begin
      mem_q[host_addr_i] <= host_wdata_i;
    end
  end

  // a read that loses to the host write stays posted at the same address
  a_denied_read_held: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    rd_req_i && !rd_gnt_o |=> rd_req_i && $stable(rd_addr_i)
  );

endmodule

// File: hdl/fetch_addr_gen.sv
/* fetch address generator: byte base and length to a run of word reads,
   with first/last flags, byte offset and tail strobe as sideband */

`timescale 1ns/1ps

module fetch_addr_gen
  import stream_pkg::*;
(
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               start_i,
  input  logic [BADDR_W-1:0] base_addr_i,
  input  logic [LEN_W-1:0]   len_i,
  input  logic               rd_gnt_i,
  input  logic               fetch_ready_i,
  output logic               busy_o,
  output logic               rd_req_o,
  output logic [WADDR_W-1:0] rd_addr_o,
  output logic               fetch_first_o,
  output logic               fetch_last_o,
  output logic [OFS_W-1:0]   fetch_ofs_o,
  output logic [STRB_W-1:0]  tail_strb_o
);

  // fetch counters hold up to ceil(len/4) + 1, one bit less than len
  logic [LEN_W-2:0]   beats;
  logic [LEN_W-2:0]   last_idx_d;
  logic [LEN_W-2:0]   last_idx_q;
  logic [LEN_W-2:0]   cnt_q;
  logic [OFS_W-1:0]   base_ofs;
  logic [OFS_W-1:0]   len_rem;
  logic [STRB_W-1:0]  tail_d;
  logic [STRB_W-1:0]  tail_q;
  logic [OFS_W-1:0]   ofs_q;
  logic [WADDR_W-1:0] word_addr_q;
  logic               busy_q;
  logic               start;
  logic               fire;

  assign start = start_i & ~busy_q;
  assign fire  = rd_req_o & rd_gnt_i & fetch_ready_i;

  assign base_ofs = base_addr_i[OFS_W-1:0];
  assign len_rem  = len_i[OFS_W-1:0];

  // output beats = ceil(len / 4), one extra bit keeps len + 3 from wrapping
  assign beats = (LEN_W-1)'(({1'b0, len_i} + (LEN_W+1)'(STRB_W - 1)) >> OFS_W);

  // a misaligned range needs one more word than it has beats
  assign last_idx_d = (base_ofs == '0) ? beats - 1'b1 : beats;

  // low (len mod 4) lanes on the final beat, full word otherwise
  always_comb begin
    tail_d = '1;
    if (len_rem != '0) begin
      tail_d = ~({STRB_W{1'b1}} << len_rem);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
    end else if (start) begin
      busy_q <= 1'b1;
      cnt_q  <= '0;
    end else if (fire) begin
      cnt_q <= cnt_q + 1'b1;
      // the last fetch coincides with the last beat handshake
      if (fetch_last_o) begin
        busy_q <= 1'b0;
      end
    end
  end

  // transfer description, loaded on start
  always_ff @(posedge clk_i) begin
    if (start) begin
      word_addr_q <= base_addr_i[BADDR_W-1:OFS_W];
      ofs_q       <= base_ofs;
      last_idx_q  <= last_idx_d;
      tail_q      <= tail_d;
    end else if (fire) begin
      // wraps at the end of the memory
      word_addr_q <= word_addr_q + 1'b1;
    end
  end

  assign busy_o        = busy_q;
  assign rd_req_o      = busy_q;
  assign rd_addr_o     = word_addr_q;
  assign fetch_first_o = (cnt_q == '0);
  assign fetch_last_o  = (cnt_q == last_idx_q);
  assign fetch_ofs_o   = ofs_q;
  assign tail_strb_o   = tail_q;

  // a pending fetch keeps its address and flags until it completes
  a_fetch_hold: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    rd_req_o && !fire |=> $stable(rd_addr_o) && $stable(fetch_first_o) &&
                          $stable(fetch_last_o)
  );

endmodule

// File: hdl/source_realign.sv
/* realigner that joins consecutive fetched words into aligned output beats,
   absorbs the first word of a misaligned range and passes aligned data through */

`timescale 1ns/1ps

module source_realign
  import stream_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              fetch_valid_i,
  input  logic [DATA_W-1:0] fetch_data_i,
  input  logic              fetch_first_i,
  input  logic              fetch_last_i,
  input  logic [OFS_W-1:0]  fetch_ofs_i,
  input  logic [STRB_W-1:0] tail_strb_i,
  input  logic              out_ready_i,
  output logic              fetch_ready_o,
  output logic              out_valid_o,
  output logic [DATA_W-1:0] out_data_o,
  output logic [STRB_W-1:0] out_strb_o,
  output logic              out_last_o
);

  logic [OFS_W-1:0]   ofs_q;
  logic [OFS_W-1:0]   ofs_cur;
  logic [DATA_W-1:0]  prev_q;
  logic [OFS_W+3:0]   sh_lo;
  logic [OFS_W+3:0]   sh_hi;
  logic               absorb;
  logic               fetch_fire;

  // offset is only latched once the first fetch completes
  assign ofs_cur = fetch_first_i ? fetch_ofs_i : ofs_q;

  // first word of a misaligned range yields no beat
  assign absorb = fetch_first_i & (fetch_ofs_i != '0);

  assign fetch_fire = fetch_valid_i & fetch_ready_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ofs_q <= '0;
    end else if (fetch_fire && fetch_first_i) begin
      ofs_q <= fetch_ofs_i;
    end
  end

  // previous word, needed for the low bytes of the next beat
  always_ff @(posedge clk_i) begin
    if (fetch_fire) begin
      prev_q <= fetch_data_i;
    end
  end

  // byte offset to bit shifts
  assign sh_lo = {1'b0, ofs_cur, 3'b000};
  assign sh_hi = (OFS_W+4)'(DATA_W) - sh_lo;

  always_comb begin
    out_data_o = fetch_data_i;
    if (ofs_cur != '0) begin
      // upper bytes of the older word, then lower bytes of the newer one
      out_data_o = (prev_q >> sh_lo) | (fetch_data_i << sh_hi);
    end
  end

  assign out_valid_o   = fetch_valid_i & ~absorb;
  assign fetch_ready_o = absorb | out_ready_i;

  // partial strobe only on the final beat
  assign out_strb_o = fetch_last_i ? tail_strb_i : '1;
  assign out_last_o = fetch_last_i;

  // a stalled beat that stays valid keeps its contents
  a_out_stable: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    out_valid_o && !out_ready_i |=>
      !out_valid_o ||
      ($stable(out_data_o) && $stable(out_strb_o) && $stable(out_last_o))
  );

endmodule

// File: hdl/load_streamer.sv
/* load streamer top: shared memory, fetch address generator and realigner */

`timescale 1ns/1ps

module load_streamer
  import stream_pkg::*;
(
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               host_we_i,
  input  logic [WADDR_W-1:0] host_addr_i,
  input  logic [DATA_W-1:0]  host_wdata_i,
  input  logic               start_i,
  input  logic [BADDR_W-1:0] base_addr_i,
  input  logic [LEN_W-1:0]   len_i,
  input  logic               out_ready_i,
  output logic               busy_o,
  output logic               out_valid_o,
  output logic [DATA_W-1:0]  out_data_o,
  output logic [STRB_W-1:0]  out_strb_o,
  output logic               out_last_o
);

  logic               rd_req;
  logic               rd_gnt;
  logic [WADDR_W-1:0] rd_addr;
  logic [DATA_W-1:0]  rd_data;
  logic               fetch_ready;
  logic               fetch_first;
  logic               fetch_last;
  logic [OFS_W-1:0]   fetch_ofs;
  logic [STRB_W-1:0]  tail_strb;

  shared_mem mem_i (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .host_we_i    ( host_we_i    ),
    .host_addr_i  ( host_addr_i  ),
    .host_wdata_i ( host_wdata_i ),
    .rd_req_i     ( rd_req       ),
    .rd_addr_i    ( rd_addr      ),
    .rd_gnt_o     ( rd_gnt       ),
    .rd_data_o    ( rd_data      )
  );

  fetch_addr_gen addr_gen_i (
    .clk_i         ( clk_i       ),
    .rst_ni        ( rst_ni      ),
    .start_i       ( start_i     ),
    .base_addr_i   ( base_addr_i ),
    .len_i         ( len_i       ),
    .rd_gnt_i      ( rd_gnt      ),
    .fetch_ready_i ( fetch_ready ),
    .busy_o        ( busy_o      ),
    .rd_req_o      ( rd_req      ),
    .rd_addr_o     ( rd_addr     ),
    .fetch_first_o ( fetch_first ),
    .fetch_last_o  ( fetch_last  ),
    .fetch_ofs_o   ( fetch_ofs   ),
    .tail_strb_o   ( tail_strb   )
  );

  // a granted read is a valid fetched word
  source_realign realign_i (
    .clk_i         ( clk_i       ),
    .rst_ni        ( rst_ni      ),
    .fetch_valid_i ( rd_gnt      ),
    .fetch_data_i  ( rd_data     ),
    .fetch_first_i ( fetch_first ),
    .fetch_last_i  ( fetch_last  ),
    .fetch_ofs_i   ( fetch_ofs   ),
    .tail_strb_i   ( tail_strb   ),
    .out_ready_i   ( out_ready_i ),
    .fetch_ready_o ( fetch_ready ),
    .out_valid_o   ( out_valid_o ),
    .out_data_o    ( out_data_o  ),
    .out_strb_o    ( out_strb_o  ),
    .out_last_o    ( out_last_o  )
  );

endmodule

// File: tests/tb_load_streamer.sv
/* testbench for the load streamer: memory contents, transfers and expected beats come
   from a data file, run under random back-pressure and host write contention */

`timescale 1ns/1ps

module tb_load_streamer
  import stream_pkg::*;
();

  localparam int                 timeout_cycles = 200;
  localparam logic [WADDR_W-1:0] scratch_word   = 8'h80;

  logic               clk_i;
  logic               rst_ni;
  logic               host_we_i;
  logic [WADDR_W-1:0] host_addr_i;
  logic [DATA_W-1:0]  host_wdata_i;
  logic               start_i;
  logic [BADDR_W-1:0] base_addr_i;
  logic [LEN_W-1:0]   len_i;
  logic               out_ready_i;
  logic               busy_o;
  logic               out_valid_o;
  logic [DATA_W-1:0]  out_data_o;
  logic [STRB_W-1:0]  out_strb_o;
  logic               out_last_o;

  logic [31:0]        rng_q;
  logic               held_valid;
  logic [DATA_W-1:0]  held_data;
  logic [STRB_W-1:0]  held_strb;
  logic               held_last;
  logic [DATA_W-1:0]  exp_data [$];
  logic [STRB_W-1:0]  exp_strb [$];
  logic               exp_last [$];

  load_streamer dut_i (.*);

  initial begin
    clk_i = 1'b0;
    forever begin
      #2 clk_i = ~clk_i;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // byte lanes selected by a strobe
  function automatic logic [DATA_W-1:0] lane_mask(input logic [STRB_W-1:0] strb);
    logic [DATA_W-1:0] m;
    m = '0;
    for (int i = 0; i < STRB_W; i++) begin
      if (strb[i]) begin
        m[8*i +: 8] = 8'hff;
      end
    end
    return m;
  endfunction

  task automatic abort_run();
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_val(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("Mismatch at time %0t: %s, got %h expected %h", $time, what, got, exp);
      abort_run();
    end
  endtask

  // one clock: drive on the rising edge, sample in mid-cycle
  task automatic tick(input bit contend);
    logic [31:0] r;
    rng_q = xorshift32(rng_q);
    r = rng_q;
    @(posedge clk_i);
    start_i      <= 1'b0;
    out_ready_i  <= (r[1:0] != 2'b00);
    host_we_i    <= contend & (r[5:4] == 2'b00);
    host_addr_i  <= scratch_word;
    host_wdata_i <= r ^ 32'h5a5a_0000;
    @(negedge clk_i);
    // a stalled beat must come back unchanged
    if (held_valid && out_valid_o) begin
      check_val(out_data_o, held_data, "stalled beat data changed");
      check_val(32'(out_strb_o), 32'(held_strb), "stalled beat strobe changed");
      check_val(32'(out_last_o), 32'(held_last), "stalled beat last flag changed");
    end
    if (out_valid_o) begin
      held_valid = !out_ready_i;
      held_data  = out_data_o;
      held_strb  = out_strb_o;
      held_last  = out_last_o;
    end
  endtask

  task automatic host_write(input logic [WADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
    @(posedge clk_i);
    host_we_i    <= 1'b1;
    host_addr_i  <= addr;
    host_wdata_i <= data;
    @(posedge clk_i);
    host_we_i <= 1'b0;
  endtask

  task automatic run_transfer(input logic [BADDR_W-1:0] base, input logic [LEN_W-1:0] len,
                              input bit contend);
    int                n_beats;
    int                wait_cnt;
    bit                accepted;
    logic [DATA_W-1:0] mask;
    n_beats = exp_data.size();
    @(posedge clk_i);
    start_i     <= 1'b1;
    base_addr_i <= base;
    len_i       <= len;
    out_ready_i <= 1'b0;
    host_we_i   <= 1'b0;
    held_valid = 1'b0;
    for (int k = 0; k < n_beats; k++) begin
      wait_cnt = 0;
      accepted = 1'b0;
      while (!accepted) begin
        tick(contend);
        if (k == 0 && wait_cnt == 0) begin
          check_val(32'(busy_o), 32'd1, "busy one cycle after start");
        end
        if (out_valid_o && out_ready_i) begin
          mask = lane_mask(exp_strb[k]);
          check_val(out_data_o & mask, exp_data[k] & mask, $sformatf("beat %0d data", k));
          check_val(32'(out_strb_o), 32'(exp_strb[k]), $sformatf("beat %0d strobe", k));
          check_val(32'(out_last_o), 32'(exp_last[k]), $sformatf("beat %0d last flag", k));
          accepted = 1'b1;
        end else begin
          wait_cnt++;
          if (wait_cnt > timeout_cycles) begin
            $display("Timeout waiting for beat %0d of transfer at base %h", k, base);
            abort_run();
          end
        end
      end
    end
    // no beat may follow the last one
    wait_cnt = 0;
    tick(1'b0);
    while (busy_o) begin
      if (out_valid_o) begin
        $display("Extra output beat after the last beat at time %0t", $time);
        abort_run();
      end
      wait_cnt++;
      if (wait_cnt > timeout_cycles) begin
        $display("Timeout waiting for busy to fall after transfer at base %h", base);
        abort_run();
      end
      tick(1'b0);
    end
    check_val(32'(out_valid_o), 32'd0, "valid after busy fell");
  endtask

  initial begin
    int                 fd;
    int                 n;
    int                 n_transfers;
    int                 n_beats;
    int                 contend;
    string              line;
    logic [7:0]         kind;
    logic [WADDR_W-1:0] waddr;
    logic [DATA_W-1:0]  wdata;
    logic [BADDR_W-1:0] base;
    logic [LEN_W-1:0]   len;
    logic [DATA_W-1:0]  edata;
    logic [STRB_W-1:0]  estrb;
    logic               elast;
    rst_ni       <= 1'b0;
    host_we_i    <= 1'b0;
    host_addr_i  <= '0;
    host_wdata_i <= '0;
    start_i      <= 1'b0;
    base_addr_i  <= '0;
    len_i        <= '0;
    out_ready_i  <= 1'b0;
    rng_q = 32'd49;
    held_valid = 1'b0;
    n_transfers = 0;
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    check_val(32'(busy_o), 32'd0, "busy after reset");
    check_val(32'(out_valid_o), 32'd0, "out valid after reset");

    fd = $fopen("tests/load_testdata.txt", "r");
    if (fd == 0) begin
      $display("Could not open the data file tests/load_testdata.txt");
      abort_run();
    end
    while (!$feof(fd)) begin
      n = $fscanf(fd, " %c", kind);
      if (n != 1) begin
        break;
      end
      case (kind)
        "#": n = $fgets(line, fd);
        "W": begin
          n = $fscanf(fd, "%h %h", waddr, wdata);
          host_write(waddr, wdata);
        end
        "T": begin
          n = $fscanf(fd, "%h %h %d", base, len, contend);
          // beats = ceil(len / 4)
          n_beats = (int'(len) + 3) / 4;
          exp_data.delete();
          exp_strb.delete();
          exp_last.delete();
          for (int k = 0; k < n_beats; k++) begin
            n = $fscanf(fd, " %c %h %h %h", kind, edata, estrb, elast);
            if (n != 4 || kind != "E") begin
              $display("Data file is missing beat %0d of transfer %0d", k, n_transfers);
              abort_run();
            end
            exp_data.push_back(edata);
            exp_strb.push_back(estrb);
            exp_last.push_back(elast);
          end
          run_transfer(base, len, contend != 0);
          n_transfers++;
        end
        default: begin
          $display("Unknown line kind '%c' in the data file", kind);
          abort_run();
        end
      endcase
    end
    $fclose(fd);

    if (n_transfers == 0) begin
      $display("The data file holds no transfer");
      abort_run();
    end else begin
      $display("RESULT: PASS");
      $finish;
    end
  end

endmodule

// File: tests/load_testdata.txt
# W word_addr data | T byte_base byte_len contend | E data strb last
# addresses, lengths, data and strobes in hex; byte value = low byte of its byte address
W 10 43424140
W 11 47464544
W 12 4b4a4948
W 13 4f4e4d4c
W 14 53525150
W 15 57565554
W 16 5b5a5958
W 17 5f5e5d5c
W ff fffefdfc
W 00 03020100
W 01 07060504
# aligned, 16 bytes
T 040 010 0
E 43424140 f 0
E 47464544 f 0
E 4b4a4948 f 0
E 4f4e4d4c f 1
# offset 1, 8 bytes
T 041 008 0
E 44434241 f 0
E 48474645 f 1
# offset 2, 7 bytes, host contention
T 042 007 1
E 45444342 f 0
E 49484746 7 1
# offset 3, 9 bytes, host contention
T 047 009 1
E 4a494847 f 0
E 4e4d4c4b f 0
E 5251504f 1 1
# aligned, 14 bytes, host contention
T 050 00e 1
E 53525150 f 0
E 57565554 f 0
E 5b5a5958 f 0
E 5f5e5d5c 3 1
# offset 2 across the top of memory
T 3fe 006 1
E 0100fffe f 0
E 05040302 3 1
# single byte, offset 1
T 045 001 0
E 48474645 1 1

// File: tb.f
hdl/stream_pkg.sv
hdl/shared_mem.sv
hdl/fetch_addr_gen.sv
hdl/source_realign.sv
hdl/load_streamer.sv
tests/tb_load_streamer.sv

// File: run.sh
#!/bin/sh
# build and run the load streamer testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --assert --top-module tb_load_streamer -f tb.f -o tb_load_streamer
out=$(./obj_dir/tb_load_streamer 2>&1) || true
echo "$out"
if echo "$out" | grep -q "RESULT: PASS"; then
  exit 0
fi
echo "simulation did not pass"
exit 1
